// File: hdl/gpio_macros.svh
`ifndef GPIO_MACROS_SVH
`define GPIO_MACROS_SVH

// LEDs on the front-panel shift register chain
`define GPIO_LED_COUNT 16

// clock cycles per prescale tick minus one, 63 on the board
`define GPIO_SREG_PRESCALE 3

// front-panel LEDs are active low
`define GPIO_SREG_INVERT 1

// cycles between heartbeat toggles
`define GPIO_HEARTBEAT_DIV 50

// host register map
`define GPIO_ADDR_RED   4'd0
`define GPIO_ADDR_GREEN 4'd1
`define GPIO_ADDR_AUX   4'd2

`endif

// File: hdl/gpio_pkg.sv
`include "gpio_macros.svh"

package gpio_pkg;

    // host register access
    typedef logic [3:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // one colour group of front-panel LEDs
    typedef logic [7:0] led_byte_t;

    // board-management or expansion LEDs
    typedef logic [1:0] led_pair_t;

    // red/green interleaved word for the serial chain
    typedef logic [`GPIO_LED_COUNT-1:0] led_word_t;

    // serial driver states
    typedef enum logic [1:0] {
        state_idle,
        state_shift_low,
        state_shift_high,
        state_load
    } sreg_state_t;

endpackage

// File: hdl/led_regs.sv
`timescale 1ns/1ps
`include "gpio_macros.svh"

module led_regs import gpio_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    output reg_data_t reg_rdata,
    output logic      reg_done,
    output led_byte_t led_red,
    output led_byte_t led_green,
    output led_pair_t led_exp,
    output logic      led_status
);

// expansion pair in the low bits, status LED just above
localparam int AUX_W = $bits(led_pair_t) + 1;
localparam int BYTE_W = $bits(led_byte_t);

led_byte_t        red_reg;
led_byte_t        green_reg;
logic [AUX_W-1:0] aux_reg;
reg_data_t        rd_mux;

// register writes
always_ff @(posedge clk) begin
    if (reset) begin
        red_reg   <= '0;
        green_reg <= '0;
        aux_reg   <= '0;
    end else if (reg_wr) begin
        case (reg_addr)
            `GPIO_ADDR_RED: begin
                red_reg <= reg_wdata[BYTE_W-1:0];
            end
            `GPIO_ADDR_GREEN: begin
                green_reg <= reg_wdata[BYTE_W-1:0];
            end
            `GPIO_ADDR_AUX: begin
                aux_reg <= reg_wdata[AUX_W-1:0];
            end
            default: begin
                // unmapped, write dropped
            end
        endcase
    end
end

// read-back, stored bits zero extended
always_comb begin
    case (reg_addr)
        `GPIO_ADDR_RED:   rd_mux = reg_data_t'(red_reg);
        `GPIO_ADDR_GREEN: rd_mux = reg_data_t'(green_reg);
        `GPIO_ADDR_AUX:   rd_mux = reg_data_t'(aux_reg);
        default:          rd_mux = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (reg_rd) begin
        reg_rdata <= rd_mux;
    end
end

// one done pulse per access
always_ff @(posedge clk) begin
    if (reset) begin
        reg_done <= 1'b0;
    end else begin
        reg_done <= reg_wr | reg_rd;
    end
end

assign led_red    = red_reg;
assign led_green  = green_reg;
assign led_exp    = aux_reg[$bits(led_pair_t)-1:0];
assign led_status = aux_reg[AUX_W-1];

// done answers each strobe one cycle later, and nothing else
a_done_timing: assert property (
    @(posedge clk) disable iff (reset)
    reg_done == $past(reg_wr || reg_rd)
) else $error("reg_done out of step with the access strobes");

// the host side never overlaps a read with a write
a_no_overlap: assert property (
    @(posedge clk) disable iff (reset)
    !(reg_wr && reg_rd)
) else $error("read and write strobes in the same cycle");

endmodule

// File: hdl/led_heartbeat.sv
`timescale 1ns/1ps
`include "gpio_macros.svh"

module led_heartbeat (
    input  logic clk,
    input  logic reset,
    output logic beat
);

localparam int DIV = `GPIO_HEARTBEAT_DIV;
localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

logic [CNT_W-1:0] div_cnt;
logic             wrap;

// last cycle of each period
assign wrap = (div_cnt == CNT_W'(DIV - 1));

always_ff @(posedge clk) begin
    if (reset) begin
        div_cnt <= '0;
        beat    <= 1'b0;
    end else if (wrap) begin
        div_cnt <= '0;
        beat    <= ~beat;
    end else begin
        div_cnt <= div_cnt + 1'b1;
    end
end

endmodule

// File: hdl/led_sreg_driver.sv
`timescale 1ns/1ps
`include "gpio_macros.svh"

module led_sreg_driver import gpio_pkg::*; #(
    parameter int COUNT    = `GPIO_LED_COUNT,
    parameter int INVERT   = `GPIO_SREG_INVERT,
    parameter int PRESCALE = `GPIO_SREG_PRESCALE
) (
    input  logic      clk,
    input  logic      reset,
    input  led_word_t led,
    output logic      sreg_d,
    output logic      sreg_ld,
    output logic      sreg_clk
);

localparam int MSB = $bits(led_word_t) - 1;
localparam int BIT_W = (COUNT > 1) ? $clog2(COUNT) : 1;
localparam int PRE_W = (PRESCALE > 0) ? $clog2(PRESCALE + 1) : 1;
localparam logic INV = (INVERT != 0);

logic [PRE_W-1:0] prescale_cnt;
logic             tick;
sreg_state_t      state;
logic [BIT_W-1:0] bit_cnt;
led_word_t        shift_reg;
led_word_t        last_led;
logic             first_frame;
logic             start;

assign tick = (prescale_cnt == '0);

// new frame when the word moved, or once after reset
assign start = first_frame || (led != last_led);

// prescaler, one tick every PRESCALE+1 cycles
always_ff @(posedge clk) begin
    if (reset) begin
        prescale_cnt <= '0;
    end else if (tick) begin
        prescale_cnt <= PRE_W'(PRESCALE);
    end else begin
        prescale_cnt <= prescale_cnt - 1'b1;
    end
end

// frame FSM, all outputs move on a tick only
always_ff @(posedge clk) begin
    if (reset) begin
        state       <= state_idle;
        bit_cnt     <= '0;
        first_frame <= 1'b1;
        sreg_d      <= INV;
        sreg_clk    <= 1'b0;
        sreg_ld     <= 1'b0;
    end else if (tick) begin
        case (state)
            state_idle: begin
                if (start) begin
                    // capture tick doubles as setup of the first bit
                    sreg_d      <= led[MSB] ^ INV;
                    bit_cnt     <= '0;
                    first_frame <= 1'b0;
                    state       <= state_shift_low;
                end
            end
            state_shift_low: begin
                sreg_clk <= 1'b1;
                state    <= state_shift_high;
            end
            state_shift_high: begin
                sreg_clk <= 1'b0;
                if (bit_cnt == BIT_W'(COUNT - 1)) begin
                    sreg_ld <= 1'b1;
                    state   <= state_load;
                end else begin
                    sreg_d  <= shift_reg[MSB] ^ INV;
                    bit_cnt <= bit_cnt + 1'b1;
                    state   <= state_shift_low;
                end
            end
            state_load: begin
                sreg_ld <= 1'b0;
                state   <= state_idle;
            end
            default: begin
                state <= state_idle;
            end
        endcase
    end
end

// word being shifted, MSB first, and a copy of what went out
always_ff @(posedge clk) begin
    if (tick) begin
        if (state == state_idle && start) begin
            shift_reg <= led << 1;
            last_led  <= led;
        end else if (state == state_shift_high) begin
            shift_reg <= shift_reg << 1;
        end
    end
end

// latch strobe never overlaps a shift clock
a_ld_clk_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(sreg_ld && sreg_clk)
) else $error("sreg_ld and sreg_clk high together");

// data held for the whole high phase of the shift clock
a_d_stable_high: assert property (
    @(posedge clk) disable iff (reset)
    ($past(sreg_clk) && sreg_clk) |-> $stable(sreg_d)
) else $error("sreg_d changed while sreg_clk high");

endmodule

// File: hdl/fpga_gpio.sv
`timescale 1ns/1ps
`include "gpio_macros.svh"

module fpga_gpio import gpio_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // host register port
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    output reg_data_t reg_rdata,
    output logic      reg_done,
    // direct LEDs
    output led_pair_t led_bmc,
    output led_pair_t led_exp,
    // front-panel shift register
    output logic      sreg_d,
    output logic      sreg_ld,
    output logic      sreg_clk
);

led_byte_t led_red;
led_byte_t led_green;
led_word_t led_merged;
logic      led_status;
logic      beat;

led_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .reg_done   (reg_done),
    .led_red    (led_red),
    .led_green  (led_green),
    .led_exp    (led_exp),
    .led_status (led_status)
);

led_heartbeat u_heartbeat (
    .clk   (clk),
    .reset (reset),
    .beat  (beat)
);

// even positions red, odd positions green
for (genvar i = 0; i < $bits(led_byte_t); i++) begin : g_merge
    assign led_merged[2*i]   = led_red[i];
    assign led_merged[2*i+1] = led_green[i];
end

// heartbeat on bit 0, host status on bit 1
assign led_bmc = {led_status, beat};

led_sreg_driver #(
    .COUNT    (`GPIO_LED_COUNT),
    .INVERT   (`GPIO_SREG_INVERT),
    .PRESCALE (`GPIO_SREG_PRESCALE)
) u_sreg (
    .clk      (clk),
    .reset    (reset),
    .led      (led_merged),
    .sreg_d   (sreg_d),
    .sreg_ld  (sreg_ld),
    .sreg_clk (sreg_clk)
);

endmodule

// File: tb/gpio_checker.sv
`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpio_checker import gpio_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    input  reg_data_t reg_rdata,
    input  logic      reg_done,
    input  led_pair_t led_bmc,
    input  led_pair_t led_exp,
    input  logic      sreg_d,
    input  logic      sreg_ld,
    input  logic      sreg_clk,
    input  logic      report,
    output int        errors
);

localparam int COUNT = `GPIO_LED_COUNT;
localparam int TICK = `GPIO_SREG_PRESCALE + 1;
// a frame already in flight, then the frame that carries the newest word
localparam int SETTLE = 2 * (2 * COUNT + 1) * TICK + 4 * TICK;
localparam led_word_t INV_MASK = (`GPIO_SREG_INVERT != 0) ? {COUNT{1'b1}} : {COUNT{1'b0}};

// register model
led_byte_t  m_red;
led_byte_t  m_green;
logic [2:0] m_aux;
led_word_t  m_word;
reg_data_t  read_exp;

led_word_t  shift_word;
led_word_t  last_frame;
led_word_t  cand[$];
logic       prev_reset;
logic       prev_strobe;
logic       prev_rd;
logic       prev_sclk;
logic       prev_ld;
logic       prev_beat;
int         fails [1:5];
int         checks [1:5];
int         clk_count;
int         frames;
int         quiet;
int         settled;
int         since_toggle;
int         toggles;

function automatic led_word_t interleave(led_byte_t red, led_byte_t green);
    led_word_t w;
    for (int i = 0; i < COUNT; i++) begin
        w[i] = (i % 2 == 0) ? red[i / 2] : green[i / 2];
    end
    return w;
endfunction

function automatic reg_data_t expected_read(reg_addr_t addr);
    case (addr)
        `GPIO_ADDR_RED:   return {24'h0, m_red};
        `GPIO_ADDR_GREEN: return {24'h0, m_green};
        `GPIO_ADDR_AUX:   return {29'h0, m_aux};
        default:          return '0;
    endcase
endfunction

function automatic string test_name(int t);
    case (t)
        1:       return "reset state";
        2:       return "read-back";
        3:       return "direct LEDs";
        4:       return "serial frame";
        default: return "heartbeat";
    endcase
endfunction

task automatic compare(input int test, input string name, input logic [31:0] exp,
                       input logic [31:0] act);
    checks[test]++;
    if (exp !== act) begin
        $display("MISMATCH at %0t ns: %s expected %0h actual %0h", $time, name, exp, act);
        fails[test]++;
    end
endtask

// word rebuilt at the latch, inversion undone
task automatic check_frame();
    led_word_t word;
    logic      found;
    word = shift_word ^ INV_MASK;
    found = 1'b0;
    foreach (cand[i]) begin
        if (cand[i] == word) begin
            found = 1'b1;
        end
    end
    frames++;
    checks[4]++;
    if (!found) begin
        $display("MISMATCH at %0t ns: sreg word expected %0h actual %0h", $time, cand[$], word);
        fails[4]++;
    end
    compare(4, "sreg_clk count", COUNT, clk_count);
    if (frames == 1) begin
        compare(1, "first frame sreg_d bits", INV_MASK, shift_word);
    end
    last_frame = word;
    cand.delete();
    clk_count = 0;
endtask

always @(posedge clk) begin
    if (reset) begin
        m_red = '0;
        m_green = '0;
        m_aux = '0;
        prev_strobe = 1'b0;
        prev_rd = 1'b0;
        cand.delete();
        clk_count = 0;
        quiet = 0;
        toggles = 0;
    end else begin
        if (prev_reset) begin
            compare(1, "sreg_ld", 0, sreg_ld);
            compare(1, "sreg_clk", 0, sreg_clk);
            compare(1, "reg_done", 0, reg_done);
            compare(1, "led_bmc[0]", 0, led_bmc[0]);
        end
        // done one cycle after each strobe
        compare(2, "reg_done", prev_strobe, reg_done);
        if (prev_rd) begin
            compare(2, "reg_rdata", read_exp, reg_rdata);
        end
        compare(3, "led_exp", m_aux[1:0], led_exp);
        compare(3, "led_bmc[1]", m_aux[2], led_bmc[1]);
        // words in effect before the first shift clock of a frame
        m_word = interleave(m_red, m_green);
        if (clk_count == 0) begin
            cand.push_back(m_word);
        end
        if (sreg_clk && !prev_sclk) begin
            shift_word = {shift_word[COUNT-2:0], sreg_d};
            clk_count++;
        end
        if (sreg_ld && !prev_ld) begin
            check_frame();
        end
        if (quiet == SETTLE) begin
            settled++;
            compare(4, "settled sreg word", m_word, last_frame);
        end
        since_toggle++;
        if (led_bmc[0] !== prev_beat) begin
            if (toggles > 0) begin
                compare(5, "heartbeat period", `GPIO_HEARTBEAT_DIV, since_toggle);
            end
            toggles++;
            since_toggle = 0;
        end
        // model takes this cycle's strobes
        prev_strobe = reg_wr || reg_rd;
        prev_rd = reg_rd;
        read_exp = expected_read(reg_addr);
        quiet = reg_wr ? 0 : quiet + 1;
        if (reg_wr) begin
            case (reg_addr)
                `GPIO_ADDR_RED:   m_red = reg_wdata[7:0];
                `GPIO_ADDR_GREEN: m_green = reg_wdata[7:0];
                `GPIO_ADDR_AUX:   m_aux = reg_wdata[2:0];
                default:          ;
            endcase
        end
    end
    prev_reset = reset;
    prev_sclk = sreg_clk;
    prev_ld = sreg_ld;
    prev_beat = led_bmc[0];
end

always @(posedge report) begin
    int total_checks;
    int total_fails;
    total_checks = 0;
    total_fails = 0;
    if (frames == 0 || settled == 0) begin
        $display("serial frame: no loaded frame or no settled frame was seen");
        fails[4]++;
    end
    if (toggles < 2) begin
        $display("heartbeat: LED toggled fewer than two times");
        fails[5]++;
    end
    for (int t = 1; t <= 5; t++) begin
        $display("test %0d %s: %0d checks, %0d errors", t, test_name(t), checks[t], fails[t]);
        total_checks += checks[t];
        total_fails += fails[t];
    end
    $display("all tests: %0d checks, %0d errors", total_checks, total_fails);
    errors = total_fails;
end

endmodule

// File: tb/tb_fpga_gpio.sv
`timescale 1ns/1ps
`include "gpio_macros.svh"

module tb_fpga_gpio import gpio_pkg::*; ();

localparam int PERIOD = 40;
localparam int TICK = `GPIO_SREG_PRESCALE + 1;
localparam int FRAME = (2 * `GPIO_LED_COUNT + 1) * TICK;
localparam int PHASES = 8;
localparam int OPS = 24;
localparam int MAX_GAP = 3;
localparam int DONE_WAIT = 4;
// frame in flight plus the one that follows, with some slack
localparam int QUIET = 2 * FRAME + 6 * TICK;
localparam int LIMIT = 3 + PHASES * (OPS * (2 + DONE_WAIT + MAX_GAP) + QUIET + 8) + 200;

logic      clk;
logic      reset;
logic      reg_wr;
logic      reg_rd;
reg_addr_t reg_addr;
reg_data_t reg_wdata;
reg_data_t reg_rdata;
logic      reg_done;
led_pair_t led_bmc;
led_pair_t led_exp;
logic      sreg_d;
logic      sreg_ld;
logic      sreg_clk;
logic      report;
int        errors;
int        done_misses;
integer    seed;

fpga_gpio u_dut (.*);

gpio_checker u_chk (.*);

initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
end

task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
endtask

// one strobe, then wait for reg_done
task automatic do_access(input logic is_write, input reg_addr_t addr, input reg_data_t data);
    int waited;
    waited = 0;
    reg_addr = addr;
    reg_wdata = data;
    reg_wr = is_write;
    reg_rd = !is_write;
    @(negedge clk);
    reg_wr = 1'b0;
    reg_rd = 1'b0;
    while (!reg_done && waited < DONE_WAIT) begin
        @(negedge clk);
        waited++;
    end
    if (!reg_done) begin
        $display("no reg_done within %0d cycles for access at address %0d", DONE_WAIT, addr);
        done_misses++;
    end
endtask

task automatic run_phase();
    logic      is_write;
    reg_addr_t addr;
    reg_data_t data;
    for (int i = 0; i < OPS; i++) begin
        is_write = ($unsigned($random(seed)) % 5) < 3;
        addr = reg_addr_t'($unsigned($random(seed)) % 4);
        data = $random(seed);
        do_access(is_write, addr, data);
        idle_cycles($unsigned($random(seed)) % (MAX_GAP + 1));
    end
endtask

initial begin
    seed = 98;
    done_misses = 0;
    reset = 1'b1;
    reg_wr = 1'b0;
    reg_rd = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    report = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int p = 0; p < PHASES; p++) begin
        run_phase();
        // some phases stay quiet long enough for a full frame
        if (p == PHASES - 1 || ($random(seed) & 1)) begin
            idle_cycles(QUIET);
        end else begin
            idle_cycles($unsigned($random(seed)) % 8);
        end
    end
    report = 1'b1;
    // summary settles before the next clock edge can add checks
    #1;
    if (errors == 0 && done_misses == 0) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

initial begin
    #(LIMIT * PERIOD);
    $display("watchdog expired: run did not finish within %0d clock cycles", LIMIT);
    $display("TEST FAILED");
    $finish;
end

endmodule

// File: src.f
+incdir+hdl
hdl/gpio_pkg.sv
hdl/led_regs.sv
hdl/led_heartbeat.sv
hdl/led_sreg_driver.sv
hdl/fpga_gpio.sv
tb/gpio_checker.sv
tb/tb_fpga_gpio.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the fpga_gpio testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_fpga_gpio -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
